// File: design/rf_cmd_pkg.sv
`default_nettype none

package rf_cmd_pkg;

    // Mode 3 command header bytes
    localparam logic [7:0] cmd_load_keep   = 8'hC0;
    localparam logic [7:0] cmd_ret_config  = 8'hC1;
    localparam logic [7:0] cmd_load_temp   = 8'hC2;
    localparam logic [7:0] cmd_ret_version = 8'hC3;
    localparam logic [7:0] cmd_reset       = 8'hC4;

    // Version reply, index 0 goes out first
    localparam logic [3:0][7:0] version_bytes = {8'h02, 8'h27, 8'h32, 8'hC3};

    // Which reply the parser asks for
    localparam logic reply_config  = 1'b0;
    localparam logic reply_version = 1'b1;

    // SPED byte, MSB first
    typedef struct packed {
        logic [2:0] baud_sel;
        logic       stop_bit;
        logic [1:0] parity;
        logic [1:0] data_bits;
    } sped_fields_t;

    typedef union packed {
        logic [7:0]   raw;
        sped_fields_t fields;
    } sped_u;

    // Six-byte configuration record, in the order it is loaded and returned
    typedef struct packed {
        logic [7:0] head;
        logic [7:0] addh;
        logic [7:0] addl;
        sped_u      sped;
        logic [7:0] chan;
        logic [7:0] option;
    } cfg_rec_t;

    // 8N1 at 9600 baud
    localparam cfg_rec_t cfg_rec_default = '{
        head: 8'h00, addh: 8'h00, addl: 8'h00, sped: 8'h18, chan: 8'h00, option: 8'h00
    };

endpackage

`default_nettype wire

// File: design/rf_link_pkg.sv
`default_nettype none

package rf_link_pkg;

    // {M1, M0} pins, already synchronized
    typedef logic [1:0] mode_t;

    localparam mode_t mode_transparent = 2'd0;
    localparam mode_t mode_config      = 2'd3;

    // One received or transmitted byte, valid is a single-cycle strobe
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_strobe_t;

    // Buffer size in bytes
    localparam int fifo_depth_default = 512;

    // Fill level that starts forwarding to the node
    localparam int send_threshold_default = 58;

    // MCU quiet time before a short packet is sent
    localparam int idle_cycles_default = 500000;

endpackage

`default_nettype wire

// File: design/rf_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module rf_config_regs
    import rf_cmd_pkg::*;
    import rf_link_pkg::*;
(
    input  wire logic         mode0_clk,
    input  wire logic         rst_n,
    input  wire mode_t        mode,
    input  wire byte_strobe_t mcu_rx,
    output cfg_rec_t          cfg,
    output logic              reply_req,
    output logic              reply_kind
);

    typedef enum logic [3:0] {
        st_idle,
        st_addh,
        st_addl,
        st_sped,
        st_chan,
        st_option,
        st_cfg2,
        st_cfg3,
        st_ver2,
        st_ver3
    } parse_state_t;

    parse_state_t state;
    logic         rx_en;
    logic [7:0]   rx_byte;

    // Parser only listens in configuration mode
    assign rx_en   = mcu_rx.valid && (mode == mode_config);
    assign rx_byte = mcu_rx.data;

    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            cfg        <= cfg_rec_default;
            reply_req  <= 1'b0;
            reply_kind <= reply_config;
        end else begin
            reply_req <= 1'b0;
            if (rx_en) begin
                case (state)
                    st_idle: begin
                        case (rx_byte)
                            cmd_load_keep, cmd_load_temp: begin
                                cfg.head <= rx_byte;
                                state    <= st_addh;
                            end
                            cmd_ret_config:  state <= st_cfg2;
                            cmd_ret_version: state <= st_ver2;
                            // Accepted, nothing to do
                            cmd_reset:       state <= st_idle;
                            default:         state <= st_idle;
                        endcase
                    end
                    st_addh: begin
                        cfg.addh <= rx_byte;
                        state    <= st_addl;
                    end
                    st_addl: begin
                        cfg.addl <= rx_byte;
                        state    <= st_sped;
                    end
                    st_sped: begin
                        cfg.sped.raw <= rx_byte;
                        state        <= st_chan;
                    end
                    st_chan: begin
                        cfg.chan <= rx_byte;
                        state    <= st_option;
                    end
                    st_option: begin
                        cfg.option <= rx_byte;
                        state      <= st_idle;
                    end
                    // Second and third request bytes must repeat the first
                    st_cfg2: state <= (rx_byte == cmd_ret_config) ? st_cfg3 : st_idle;
                    st_cfg3: begin
                        state <= st_idle;
                        if (rx_byte == cmd_ret_config) begin
                            reply_req  <= 1'b1;
                            reply_kind <= reply_config;
                        end
                    end
                    st_ver2: state <= (rx_byte == cmd_ret_version) ? st_ver3 : st_idle;
                    st_ver3: begin
                        state <= st_idle;
                        if (rx_byte == cmd_ret_version) begin
                            reply_req  <= 1'b1;
                            reply_kind <= reply_version;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: design/rf_reply_seq.sv
`timescale 1ns/1ps
`default_nettype none

module rf_reply_seq
    import rf_cmd_pkg::*;
    import rf_link_pkg::*;
(
    input  wire logic     mode0_clk,
    input  wire logic     rst_n,
    input  wire cfg_rec_t cfg,
    input  wire logic     reply_req,
    input  wire logic     reply_kind,
    input  wire logic     mcu_tx_ready,
    output byte_strobe_t  mcu_tx,
    output logic          reply_busy
);

    logic       busy;
    logic       kind;
    logic [2:0] idx;
    logic       sent_q;
    logic       issue;
    logic       last;
    logic [7:0] cur_byte;

    // Next byte of the reply
    always_comb begin
        if (kind == reply_version) begin
            cur_byte = version_bytes[idx[1:0]];
        end else begin
            case (idx)
                3'd0:    cur_byte = cfg.head;
                3'd1:    cur_byte = cfg.addh;
                3'd2:    cur_byte = cfg.addl;
                3'd3:    cur_byte = cfg.sped.raw;
                3'd4:    cur_byte = cfg.chan;
                default: cur_byte = cfg.option;
            endcase
        end
    end

    assign last = (kind == reply_version) ? (idx == 3'd3) : (idx == 3'd5);

    // Skip the cycle after a start, ready is not trusted there
    assign issue  = busy && mcu_tx_ready && !sent_q;
    assign mcu_tx = '{valid: issue, data: cur_byte};

    // Covers the request cycle and the cycle after the last start
    assign reply_busy = busy || sent_q || reply_req;

    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            kind   <= reply_config;
            idx    <= 3'd0;
            sent_q <= 1'b0;
        end else begin
            sent_q <= issue;
            if (!busy) begin
                if (reply_req) begin
                    busy <= 1'b1;
                    kind <= reply_kind;
                    idx  <= 3'd0;
                end
            end else if (issue) begin
                if (last) begin
                    busy <= 1'b0;
                end else begin
                    idx <= idx + 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/rf_byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rf_byte_fifo
    import rf_link_pkg::*;
#(
    parameter int FIFO_DEPTH = fifo_depth_default
) (
    input  wire logic                            mode0_clk,
    input  wire logic                            rst_n,
    input  wire logic                            push,
    input  wire logic [7:0]                      push_byte,
    input  wire logic                            pop,
    output logic      [7:0]                      head_byte,
    output logic      [$clog2(FIFO_DEPTH+1)-1:0] count,
    output logic                                 empty,
    output logic                                 full
);

    localparam int ptr_w = $clog2(FIFO_DEPTH);
    localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

    logic [7:0]       mem [FIFO_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign empty = (count == '0);
    assign full  = (count == cnt_w'(FIFO_DEPTH));

    // Overflow bytes are lost
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Show-ahead read
    assign head_byte = mem[rd_ptr];

    always_ff @(posedge mode0_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_byte;
        end
    end

    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/rf_tx_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module rf_tx_scheduler
    import rf_link_pkg::*;
#(
    parameter int FIFO_DEPTH     = fifo_depth_default,
    parameter int SEND_THRESHOLD = send_threshold_default,
    parameter int IDLE_CYCLES    = idle_cycles_default
) (
    input  wire logic                            mode0_clk,
    input  wire logic                            rst_n,
    input  wire mode_t                           mode,
    input  wire logic                            rx_seen,
    input  wire logic [$clog2(FIFO_DEPTH+1)-1:0] count,
    input  wire logic                            empty,
    input  wire logic [7:0]                      head_byte,
    input  wire logic                            node_tx_ready,
    output logic                                 pop,
    output byte_strobe_t                         node_tx,
    output logic                                 busy
);

    localparam int tmr_w = $clog2(IDLE_CYCLES + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_send
    } sched_state_t;

    sched_state_t     state;
    logic [tmr_w-1:0] idle_cnt;
    logic             idle_done;
    logic             sent_q;

    // Cycles since the last MCU byte, saturating
    assign idle_done = (idle_cnt == tmr_w'(IDLE_CYCLES));

    // One byte per free slot, never on the cycle after a start
    assign pop     = (state == st_send) && node_tx_ready && !sent_q && !empty;
    assign node_tx = '{valid: pop, data: head_byte};
    assign busy    = (state != st_idle);

    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            idle_cnt <= '0;
        end else if (rx_seen) begin
            idle_cnt <= '0;
        end else if (!idle_done) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    always_ff @(posedge mode0_clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= st_idle;
            sent_q <= 1'b0;
        end else begin
            sent_q <= pop;
            if (mode != mode_transparent) begin
                state <= st_idle;
            end else begin
                case (state)
                    st_idle: if (!empty) state <= st_wait;
                    st_wait: begin
                        if (count >= SEND_THRESHOLD || idle_done) begin
                            state <= st_send;
                        end
                    end
                    // New pushes keep the burst going
                    st_send: if (empty) state <= st_idle;
                    default: state <= st_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: design/rf_transceiver_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rf_transceiver_ctrl
    import rf_cmd_pkg::*;
    import rf_link_pkg::*;
#(
    parameter int FIFO_DEPTH     = fifo_depth_default,
    parameter int SEND_THRESHOLD = send_threshold_default,
    parameter int IDLE_CYCLES    = idle_cycles_default
) (
    input  wire logic         mode0_clk,
    input  wire logic         rst_n,
    input  wire mode_t        mode,
    input  wire byte_strobe_t mcu_rx,
    input  wire logic         mcu_tx_ready,
    output byte_strobe_t      mcu_tx,
    input  wire logic         node_tx_ready,
    output byte_strobe_t      node_tx,
    output sped_fields_t      uart_cfg,
    output logic              aux
);

    localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

    cfg_rec_t         cfg;
    logic             reply_req;
    logic             reply_kind;
    logic             reply_busy;
    logic             rx_mode0;
    logic             fifo_push;
    logic             fifo_pop;
    logic [7:0]       head_byte;
    logic [cnt_w-1:0] fifo_count;
    logic             fifo_empty;
    logic             fifo_full;
    logic             sched_busy;

    // MCU bytes feed the radio path only in transparent mode
    assign rx_mode0  = mcu_rx.valid && (mode == mode_transparent);
    assign fifo_push = rx_mode0 && !fifo_full;

    assign uart_cfg = cfg.sped.fields;

    // Free only when nothing is pending on either path
    assign aux = !sched_busy && fifo_empty && !reply_busy;

    rf_config_regs u_config_regs (
        .mode0_clk  (mode0_clk),
        .rst_n      (rst_n),
        .mode       (mode),
        .mcu_rx     (mcu_rx),
        .cfg        (cfg),
        .reply_req  (reply_req),
        .reply_kind (reply_kind)
    );

    rf_reply_seq u_reply_seq (
        .mode0_clk    (mode0_clk),
        .rst_n        (rst_n),
        .cfg          (cfg),
        .reply_req    (reply_req),
        .reply_kind   (reply_kind),
        .mcu_tx_ready (mcu_tx_ready),
        .mcu_tx       (mcu_tx),
        .reply_busy   (reply_busy)
    );

    rf_byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_byte_fifo (
        .mode0_clk (mode0_clk),
        .rst_n     (rst_n),
        .push      (fifo_push),
        .push_byte (mcu_rx.data),
        .pop       (fifo_pop),
        .head_byte (head_byte),
        .count     (fifo_count),
        .empty     (fifo_empty),
        .full      (fifo_full)
    );

    rf_tx_scheduler #(
        .FIFO_DEPTH     (FIFO_DEPTH),
        .SEND_THRESHOLD (SEND_THRESHOLD),
        .IDLE_CYCLES    (IDLE_CYCLES)
    ) u_tx_scheduler (
        .mode0_clk     (mode0_clk),
        .rst_n         (rst_n),
        .mode          (mode),
        .rx_seen       (rx_mode0),
        .count         (fifo_count),
        .empty         (fifo_empty),
        .head_byte     (head_byte),
        .node_tx_ready (node_tx_ready),
        .pop           (fifo_pop),
        .node_tx       (node_tx),
        .busy          (sched_busy)
    );

endmodule

`default_nettype wire

// File: tb/rf_transceiver_ctrl_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rf_transceiver_ctrl_properties
    import rf_link_pkg::*;
(
    input wire logic         mode0_clk,
    input wire logic         rst_n,
    input wire mode_t        mode,
    input wire byte_strobe_t mcu_tx,
    input wire logic         mcu_tx_ready,
    input wire byte_strobe_t node_tx,
    input wire logic         node_tx_ready,
    input wire logic         reply_busy,
    input wire logic         aux
);

    // Running count of failed assertions
    int fail_count = 0;

    // A start only goes into an idle UART
    mcu_start_when_ready: assert property (
        @(posedge mode0_clk) disable iff (!rst_n) mcu_tx.valid |-> mcu_tx_ready
    ) else begin
        $error("mcu_tx start while mcu_tx_ready is low");
        fail_count++;
    end

    node_start_when_ready: assert property (
        @(posedge mode0_clk) disable iff (!rst_n) node_tx.valid |-> node_tx_ready
    ) else begin
        $error("node_tx start while node_tx_ready is low");
        fail_count++;
    end

    // Ready is not valid on the cycle right after a start
    mcu_no_back_to_back: assert property (
        @(posedge mode0_clk) disable iff (!rst_n) mcu_tx.valid |=> !mcu_tx.valid
    ) else begin
        $error("mcu_tx starts on two consecutive cycles");
        fail_count++;
    end

    node_no_back_to_back: assert property (
        @(posedge mode0_clk) disable iff (!rst_n) node_tx.valid |=> !node_tx.valid
    ) else begin
        $error("node_tx starts on two consecutive cycles");
        fail_count++;
    end

    mcu_only_in_reply: assert property (
        @(posedge mode0_clk) disable iff (!rst_n) mcu_tx.valid |-> reply_busy
    ) else begin
        $error("mcu_tx start outside a reply");
        fail_count++;
    end

    node_only_in_mode0: assert property (
        @(posedge mode0_clk) disable iff (!rst_n) node_tx.valid |-> (mode == mode_transparent)
    ) else begin
        $error("node_tx start outside transparent mode");
        fail_count++;
    end

    aux_low_while_forwarding: assert property (
        @(posedge mode0_clk) disable iff (!rst_n) node_tx.valid |-> !aux
    ) else begin
        $error("aux high while node_tx is valid");
        fail_count++;
    end

endmodule

bind rf_transceiver_ctrl rf_transceiver_ctrl_properties u_properties (
    .mode0_clk     (mode0_clk),
    .rst_n         (rst_n),
    .mode          (mode),
    .mcu_tx        (mcu_tx),
    .mcu_tx_ready  (mcu_tx_ready),
    .node_tx       (node_tx),
    .node_tx_ready (node_tx_ready),
    .reply_busy    (reply_busy),
    .aux           (aux)
);

`default_nettype wire

// File: tb/rf_transceiver_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rf_transceiver_ctrl_tb
    import rf_cmd_pkg::*;
    import rf_link_pkg::*;
();

    localparam int fifo_depth     = 16;
    localparam int send_threshold = 8;
    localparam int idle_cycles    = 40;
    localparam int n_rows         = 14;
    localparam int drain_limit    = 4 * idle_cycles + 200;
    localparam int watchdog_ns    = n_rows * 32 * (idle_cycles + 10) * 10;

    // One stimulus row with bytes listed first to last
    typedef struct packed {
        mode_t           mode;
        logic [3:0]      n_in;
        logic [0:5][7:0] in_bytes;
        logic [2:0]      n_reply;
        logic            want_rec;
        logic [0:3][7:0] reply;
        logic [3:0]      n_fwd;
    } row_t;

    logic         mode0_clk;
    logic         rst_n;
    mode_t        mode;
    byte_strobe_t mcu_rx;
    logic         mcu_tx_ready;
    byte_strobe_t mcu_tx;
    logic         node_tx_ready;
    byte_strobe_t node_tx;
    sped_fields_t uart_cfg;
    logic         aux;

    row_t        rows [n_rows];
    logic [7:0]  model_rec [6];
    logic [7:0]  mcu_got [$];
    logic [7:0]  node_got [$];
    logic [7:0]  payload [$];
    logic [15:0] lfsr_state;
    logic        aux_low_seen;
    int          value_errors;
    int          other_errors;

    rf_transceiver_ctrl #(
        .FIFO_DEPTH     (fifo_depth),
        .SEND_THRESHOLD (send_threshold),
        .IDLE_CYCLES    (idle_cycles)
    ) DUT (
        .mode0_clk     (mode0_clk),
        .rst_n         (rst_n),
        .mode          (mode),
        .mcu_rx        (mcu_rx),
        .mcu_tx_ready  (mcu_tx_ready),
        .mcu_tx        (mcu_tx),
        .node_tx_ready (node_tx_ready),
        .node_tx       (node_tx),
        .uart_cfg      (uart_cfg),
        .aux           (aux)
    );

    always #5 mode0_clk = ~mode0_clk;

    // Taps for x^16 + x^14 + x^13 + x^11 + 1 with one step per bit
    function automatic logic [7:0] lfsr_bits(input int n);
        logic [7:0] bits;
        logic       fb;
        int         i;
        bits = '0;
        for (i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            bits       = {bits[6:0], fb};
        end
        return bits;
    endfunction

    // UART stays busy for 1 to 4 cycles after a start
    task automatic hold_ready_low(input logic node);
        int hold;
        hold = 1 + int'(lfsr_bits(2));
        @(posedge mode0_clk);
        #1;
        if (node) begin
            node_tx_ready = 1'b0;
        end else begin
            mcu_tx_ready = 1'b0;
        end
        repeat (hold) @(posedge mode0_clk);
        #1;
        if (node) begin
            node_tx_ready = 1'b1;
        end else begin
            mcu_tx_ready = 1'b1;
        end
    endtask

    always begin
        @(negedge mode0_clk);
        if (mcu_tx.valid) begin
            hold_ready_low(1'b0);
        end
    end

    always begin
        @(negedge mode0_clk);
        if (node_tx.valid) begin
            hold_ready_low(1'b1);
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge mode0_clk) begin
        if (mcu_tx.valid) begin
            mcu_got.push_back(mcu_tx.data);
        end
        if (node_tx.valid) begin
            node_got.push_back(node_tx.data);
        end
        if (!aux) begin
            aux_low_seen = 1'b1;
        end
    end

    task automatic fill_table();
        rows[0]  = '{mode_config, 4'd6, 48'hC0_11_22_3A_05_44, 3'd0, 1'b0, 32'h0, 4'd0};
        rows[1]  = '{mode_config, 4'd3, 48'hC1_C1_C1_00_00_00, 3'd6, 1'b1, 32'h0, 4'd0};
        rows[2]  = '{mode_config, 4'd3, 48'hC3_C3_C3_00_00_00, 3'd4, 1'b0, 32'hC3_32_27_02, 4'd0};
        rows[3]  = '{mode_config, 4'd6, 48'hC2_A5_5A_1C_17_C4, 3'd0, 1'b0, 32'h0, 4'd0};
        rows[4]  = '{mode_config, 4'd3, 48'hC1_C1_C1_00_00_00, 3'd6, 1'b1, 32'h0, 4'd0};
        // Broken requests leave the record alone
        rows[5]  = '{mode_config, 4'd3, 48'hC1_C1_55_00_00_00, 3'd0, 1'b0, 32'h0, 4'd0};
        rows[6]  = '{mode_config, 4'd1, 48'hC4_00_00_00_00_00, 3'd0, 1'b0, 32'h0, 4'd0};
        rows[7]  = '{mode_config, 4'd1, 48'h7E_00_00_00_00_00, 3'd0, 1'b0, 32'h0, 4'd0};
        rows[8]  = '{mode_config, 4'd3, 48'hC1_C1_C1_00_00_00, 3'd6, 1'b1, 32'h0, 4'd0};
        // Mode 0 payload comes from the LFSR
        rows[9]  = '{mode_transparent, 4'd5, 48'h0, 3'd0, 1'b0, 32'h0, 4'd5};
        rows[10] = '{mode_transparent, 4'd12, 48'h0, 3'd0, 1'b0, 32'h0, 4'd12};
        // Mode 1 is idle
        rows[11] = '{2'd1, 4'd6, 48'hC0_01_02_FF_04_05, 3'd0, 1'b0, 32'h0, 4'd0};
        rows[12] = '{2'd1, 4'd3, 48'hC1_C1_C1_00_00_00, 3'd0, 1'b0, 32'h0, 4'd0};
        rows[13] = '{mode_config, 4'd3, 48'hC1_C1_C1_00_00_00, 3'd6, 1'b1, 32'h0, 4'd0};
    endtask

    task automatic check_reset_state();
        repeat (3) @(negedge mode0_clk);
        assert (aux === 1'b1) else begin
            value_errors++;
            $display("[FAIL] %0t: aux is %b after reset, expected 1", $time, aux);
        end
        assert (mcu_got.size() == 0 && node_got.size() == 0) else begin
            value_errors++;
            $display("[FAIL] %0t: strobes seen right after reset", $time);
        end
        assert (uart_cfg == 8'h18) else begin
            value_errors++;
            $display("[FAIL] %0t: uart_cfg is %h after reset, expected 18", $time, uart_cfg);
        end
    endtask

    task automatic apply_row(input int r);
        row_t       row;
        logic [7:0] exp_byte;
        int         early;
        int         cycles;
        int         first_fwd;
        int         i;
        row = rows[r];
        payload.delete();
        for (i = 0; i < row.n_in; i++) begin
            if (row.mode == mode_transparent) begin
                payload.push_back(lfsr_bits(8));
            end else begin
                payload.push_back(row.in_bytes[i]);
            end
        end
        mcu_got.delete();
        node_got.delete();
        aux_low_seen = 1'b0;
        @(posedge mode0_clk);
        #1;
        mode = row.mode;
        // One strobe every other cycle
        for (i = 0; i < row.n_in; i++) begin
            @(posedge mode0_clk);
            #1;
            mcu_rx = '{valid: 1'b1, data: payload[i]};
            @(posedge mode0_clk);
            #1;
            mcu_rx.valid = 1'b0;
        end
        early     = node_got.size();
        cycles    = 0;
        first_fwd = -1;
        while (!(aux && mcu_got.size() >= row.n_reply && node_got.size() >= row.n_fwd)
               && cycles < drain_limit) begin
            @(negedge mode0_clk);
            cycles++;
            if (first_fwd < 0 && node_got.size() > 0) begin
                first_fwd = cycles;
            end
        end
        // Room for any stray bytes
        repeat (10) @(negedge mode0_clk);
        assert (cycles < drain_limit) else begin
            other_errors++;
            $display("Row %0d: the DUT did not go idle within %0d cycles", r, drain_limit);
        end
        assert (mcu_got.size() == row.n_reply) else begin
            value_errors++;
            $display("[FAIL] %0t: row %0d sent %0d reply bytes, expected %0d",
                     $time, r, mcu_got.size(), row.n_reply);
        end
        for (i = 0; i < mcu_got.size() && i < row.n_reply; i++) begin
            exp_byte = row.want_rec ? model_rec[i] : row.reply[i];
            assert (mcu_got[i] == exp_byte) else begin
                value_errors++;
                $display("[FAIL] %0t: row %0d reply byte %0d is %h, expected %h",
                         $time, r, i, mcu_got[i], exp_byte);
            end
        end
        assert (node_got.size() == row.n_fwd) else begin
            value_errors++;
            $display("[FAIL] %0t: row %0d forwarded %0d bytes, expected %0d",
                     $time, r, node_got.size(), row.n_fwd);
        end
        for (i = 0; i < node_got.size() && i < row.n_fwd; i++) begin
            assert (node_got[i] == payload[i]) else begin
                value_errors++;
                $display("[FAIL] %0t: row %0d forwarded byte %0d is %h, expected %h",
                         $time, r, i, node_got[i], payload[i]);
            end
        end
        if (row.mode == mode_transparent && row.n_in >= send_threshold) begin
            assert (early > 0) else begin
                value_errors++;
                $display("[FAIL] %0t: row %0d no forwarding before the burst ended", $time, r);
            end
        end else begin
            assert (early == 0) else begin
                value_errors++;
                $display("[FAIL] %0t: row %0d forwarded %0d bytes early", $time, r, early);
            end
        end
        // A short burst waits out the idle timer
        if (row.mode == mode_transparent && row.n_in < send_threshold) begin
            assert (first_fwd >= idle_cycles) else begin
                value_errors++;
                $display("[FAIL] %0t: row %0d first byte forwarded after %0d cycles, expected %0d",
                         $time, r, first_fwd, idle_cycles);
            end
        end
        assert (aux_low_seen == (row.n_reply != 0 || row.n_fwd != 0)) else begin
            value_errors++;
            $display("[FAIL] %0t: row %0d aux low seen is %b", $time, r, aux_low_seen);
        end
        // Complete C0 or C2 loads in mode 3 replace the record
        if (row.mode == mode_config && row.n_in == 6
            && (payload[0] == cmd_load_keep || payload[0] == cmd_load_temp)) begin
            for (i = 0; i < 6; i++) begin
                model_rec[i] = payload[i];
            end
        end
        assert (uart_cfg == model_rec[3]) else begin
            value_errors++;
            $display("[FAIL] %0t: row %0d uart_cfg is %h, expected %h",
                     $time, r, uart_cfg, model_rec[3]);
        end
    endtask

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the test did not finish", watchdog_ns);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : main_seq
        int r;
        int assert_errors;
        $timeformat(-9, 0, " ns", 0);
        lfsr_state    = 16'd39;
        mode0_clk     = 1'b0;
        rst_n         = 1'b0;
        mode          = mode_config;
        mcu_rx        = '0;
        mcu_tx_ready  = 1'b1;
        node_tx_ready = 1'b1;
        aux_low_seen  = 1'b0;
        value_errors  = 0;
        other_errors  = 0;
        model_rec     = '{8'h00, 8'h00, 8'h00, 8'h18, 8'h00, 8'h00};
        fill_table();
        repeat (8) @(posedge mode0_clk);
        #1;
        rst_n = 1'b1;
        check_reset_state();
        for (r = 0; r < n_rows; r++) begin
            apply_row(r);
        end
        assert_errors = DUT.u_properties.fail_count;
        $display("Value errors: %0d, other errors: %0d, assertion errors: %0d",
                 value_errors, other_errors, assert_errors);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rf_transceiver_ctrl.f
design/rf_cmd_pkg.sv
design/rf_link_pkg.sv
design/rf_config_regs.sv
design/rf_reply_seq.sv
design/rf_byte_fifo.sv
design/rf_tx_scheduler.sv
design/rf_transceiver_ctrl.sv
tb/rf_transceiver_ctrl_properties.sv
tb/rf_transceiver_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := rf_transceiver_ctrl_tb
FILELIST  := rf_transceiver_ctrl.f
VFLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := STATUS: FAIL

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
